/* activation_collector.sv */
`timescale 1ns/1ps

module activation_collector (
    input  logic                           clk,
    input  logic                           rst_n,
    input  bnn_layer_pkg::neuron_bit_t     nb,
    output bnn_layer_pkg::activation_vec_t a1
);
    import bnn_layer_pkg::*;

    // bits arrive in neuron order, so shifting left leaves neuron 0 at the top
    // once the whole sweep has passed through
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a1 <= '0;
        end else if (nb.valid) begin
            a1 <= {a1[N_NEURONS-2:0], nb.fire};
        end
    end

endmodule

/* binary_neuron.sv */
`timescale 1ns/1ps

module binary_neuron (
    input  logic                       clk,
    input  logic                       rst_n,
    input  bnn_layer_pkg::pixel_vec_t  x,
    input  bnn_layer_pkg::row_read_t   rd,
    output bnn_layer_pkg::neuron_bit_t nb
);
    import bnn_layer_pkg::*;

    logic [$clog2(N_PIXELS+1)-1:0] agree;
    logic [$clog2(N_PIXELS+1)-1:0] disagree;
    logic                          fire_q;
    logic                          vld_q;

    // pixels that are off contribute nothing, the rest count as +1 or -1
    always_comb begin
        agree    = '0;
        disagree = '0;
        for (int i = 0; i < N_PIXELS; i++) begin
            if (x[i]) begin
                if (rd.row[i]) begin
                    agree = agree + 1'b1;
                end else begin
                    disagree = disagree + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd.valid) begin
            fire_q <= (agree >= disagree);  // sign of the sum, zero counts as firing
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= rd.valid;
        end
    end

    assign nb = '{valid: vld_q, fire: fire_q};

endmodule

/* bnn_layer1.sv */
`timescale 1ns/1ps

module bnn_layer1 (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start,
    input  bnn_layer_pkg::pixel_vec_t      x,
    input  bnn_layer_pkg::weight_write_t   wload,
    output bnn_layer_pkg::activation_vec_t a1,
    output logic                           busy,
    output logic                           done
);
    import bnn_layer_pkg::*;

    logic        sweep_run;
    logic        drain_run;
    logic        last_issue;
    logic        drain_end;
    logic        issue;
    neuron_idx_t rd_addr;
    row_read_t   rd;
    neuron_bit_t nb;

    neuron_sequencer u_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .last_issue (last_issue),
        .drain_end  (drain_end),
        .sweep_run  (sweep_run),
        .drain_run  (drain_run),
        .busy       (busy),
        .done       (done)
    );

    neuron_counter u_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .sweep_run  (sweep_run),
        .drain_run  (drain_run),
        .rd_addr    (rd_addr),
        .issue      (issue),
        .last_issue (last_issue),
        .drain_end  (drain_end)
    );

    weight_store u_store (
        .clk     (clk),
        .rst_n   (rst_n),
        .wload   (wload),
        .rd_addr (rd_addr),
        .issue   (issue),
        .rd      (rd)
    );

    // x goes straight in, it is held steady for the whole sweep
    binary_neuron u_neuron (
        .clk   (clk),
        .rst_n (rst_n),
        .x     (x),
        .rd    (rd),
        .nb    (nb)
    );

    activation_collector u_collector (
        .clk   (clk),
        .rst_n (rst_n),
        .nb    (nb),
        .a1    (a1)
    );

endmodule

/* bnn_layer_pkg.sv */
package bnn_layer_pkg;

    localparam int N_PIXELS     = 784;
    localparam int N_NEURONS    = 512;
    localparam int READ_LATENCY = 2;  // weight store, address in to row out
    localparam int PIPE_DEPTH   = 3;  // address issue to the bit landing in the collector

    // one bit per pixel, 1 is on and 0 is off
    typedef logic [N_PIXELS-1:0] pixel_vec_t;

    // one bit per weight, 1 stands for +1 and 0 for -1
    typedef logic [N_PIXELS-1:0] weight_row_t;

    typedef logic [N_NEURONS-1:0] activation_vec_t;  // neuron 0 in the top bit

    typedef logic [$clog2(N_NEURONS)-1:0] neuron_idx_t;

    // a single row write into the weight store
    typedef struct packed {
        logic        en;
        neuron_idx_t addr;
        weight_row_t row;
    } weight_write_t;

    // a row on its way out of the weight store
    typedef struct packed {
        logic        valid;
        weight_row_t row;
    } row_read_t;

    // the decision of one neuron
    typedef struct packed {
        logic valid;
        logic fire;
    } neuron_bit_t;

    typedef enum logic [1:0] {
        IDLE,
        SWEEP,
        DRAIN,
        DONE
    } seq_state_t;

endpackage

/* list.f */
+incdir+.
bnn_layer_pkg.sv
weight_store.sv
binary_neuron.sv
activation_collector.sv
neuron_counter.sv
neuron_sequencer.sv
bnn_layer1.sv
tb_bnn_layer1.sv

/* neuron_counter.sv */
`timescale 1ns/1ps

module neuron_counter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       sweep_run,
    input  logic                       drain_run,
    output bnn_layer_pkg::neuron_idx_t rd_addr,
    output logic                       issue,
    output logic                       last_issue,
    output logic                       drain_end
);
    import bnn_layer_pkg::*;

    logic [$clog2(PIPE_DEPTH)-1:0] drain_cnt;

    assign last_issue = issue && (rd_addr == neuron_idx_t'(N_NEURONS - 1));

    // the first read goes out one cycle after the sequencer enters SWEEP
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr <= '0;
            issue   <= 1'b0;
        end else if (last_issue || !sweep_run) begin
            rd_addr <= '0;  // park at zero for the next sweep
            issue   <= 1'b0;
        end else begin
            issue <= 1'b1;
            if (issue) begin
                rd_addr <= rd_addr + 1'b1;
            end
        end
    end

    // counts the drain cycles while the last neurons are still in flight
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drain_cnt <= '0;
        end else if (!drain_run) begin
            drain_cnt <= '0;
        end else if (!drain_end) begin
            drain_cnt <= drain_cnt + 1'b1;
        end
    end

    // high in the last of the PIPE_DEPTH drain cycles
    assign drain_end = drain_run && (drain_cnt == ($clog2(PIPE_DEPTH))'(PIPE_DEPTH - 1));

endmodule

/* neuron_sequencer.sv */
`timescale 1ns/1ps

module neuron_sequencer (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic last_issue,
    input  logic drain_end,
    output logic sweep_run,
    output logic drain_run,
    output logic busy,
    output logic done
);
    import bnn_layer_pkg::*;

    seq_state_t state;
    seq_state_t state_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start) begin  // only looked at here, a start in any other state is dropped
                    state_nxt = SWEEP;
                end
            end
            SWEEP: begin
                if (last_issue) begin
                    state_nxt = DRAIN;
                end
            end
            DRAIN: begin
                if (drain_end) begin
                    state_nxt = DONE;
                end
            end
            DONE: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    assign sweep_run = (state == SWEEP);
    assign drain_run = (state == DRAIN);
    assign done      = (state == DONE);

    // busy follows SWEEP and DRAIN one edge late, so it rises with the first read
    // and drops at the same edge that raises done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else begin
            busy <= (state == SWEEP) || (state == DRAIN && !drain_end);
        end
    end

    done_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |=> !done
    );

    // the result is never reported while the layer still claims to be working
    done_ends_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(done) |-> $fell(busy)
    );

endmodule

/* tb_bnn_checks.svh */
// expected layer output, built from the signed sum of every neuron
// an on pixel adds +1 under a 1 weight and -1 under a 0 weight, off pixels add nothing
function automatic activation_vec_t expected_activation(input pixel_vec_t img);
    activation_vec_t result;
    int              sum;

    result = '0;
    for (int k = 0; k < N_NEURONS; k++) begin
        sum = 0;
        for (int i = 0; i < N_PIXELS; i++) begin
            if (img[i] == 1'b1) begin
                if (w_ref[k][i] == 1'b1) begin
                    sum = sum + 1;
                end else begin
                    sum = sum - 1;
                end
            end
        end
        result[N_NEURONS-1-k] = (sum >= 0);  // neuron 0 is the top bit
    end
    return result;
endfunction

task automatic check_activation(
    input string           name,
    input activation_vec_t got,
    input activation_vec_t exp
);
    if (got !== exp) begin
        $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        report_failure("activation vector mismatch");
    end
endtask

task automatic check_flag(
    input string name,
    input logic  got,
    input logic  exp
);
    if (got !== exp) begin
        $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        report_failure("control flag mismatch");
    end
endtask

// random image or weight row, refilled 32 bits at a time
function automatic pixel_vec_t random_vec();
    pixel_vec_t  v;
    logic [31:0] word;

    v    = '0;
    word = '0;
    for (int i = 0; i < N_PIXELS; i++) begin
        if (i % 32 == 0) begin
            word = $urandom;
        end
        v[i] = word[i % 32];
    end
    return v;
endfunction

/* tb_bnn_layer1.sv */
`timescale 1ns/1ps

module tb_bnn_layer1;
    import bnn_layer_pkg::*;

    localparam int WAIT_LIMIT = 600;
    localparam int DONE_CYCLE = N_NEURONS + PIPE_DEPTH + 1;  // counted from the edge that takes start

    logic            clk;
    logic            rst_n;
    logic            start;
    pixel_vec_t      x;
    weight_write_t   wload;
    activation_vec_t a1;
    logic            busy;
    logic            done;

    weight_row_t     w_ref [N_NEURONS];  // what the weight store should hold
    activation_vec_t exp_a1;
    int              sweeps_run;
    int              sweeps_checked;
    logic            done_q;

    bnn_layer1 UUT (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .x     (x),
        .wload (wload),
        .a1    (a1),
        .busy  (busy),
        .done  (done)
    );

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    `include "tb_bnn_checks.svh"

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic write_row(input neuron_idx_t addr, input weight_row_t row);
        @(posedge clk);
        #1;
        wload.en   = 1'b1;
        wload.addr = addr;
        wload.row  = row;
        w_ref[addr] = row;
    endtask

    task automatic end_writes();
        @(posedge clk);
        #1;
        wload = '0;  // the last row goes in at this edge
    endtask

    // mode 0 loads all -1 weights, mode 1 all +1, anything else random rows
    task automatic load_all(input int mode);
        weight_row_t row;

        for (int k = 0; k < N_NEURONS; k++) begin
            case (mode)
                0:       row = '0;
                1:       row = '1;
                default: row = random_vec();
            endcase
            write_row(neuron_idx_t'(k), row);
        end
        end_writes();
    endtask

    // pulses start, then follows busy and done cycle by cycle up to the done pulse
    // restart_at gives the cycle of an extra start pulse, negative for none
    task automatic run_sweep(input int restart_at);
        int n;

        @(posedge clk);
        #1;
        start = 1'b1;
        sweeps_run = sweeps_run + 1;
        @(posedge clk);  // edge 0
        #1;
        start = 1'b0;
        n = 0;
        while (!done && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n = n + 1;
            start = (n == restart_at);
            check_flag("done", done, n == DONE_CYCLE);
            check_flag("busy", busy, n < DONE_CYCLE);
        end
        start = 1'b0;
        if (!done) begin
            report_failure("timeout, done did not pulse within 600 cycles of start");
        end
        @(posedge clk);
        #1;
        check_flag("done", done, 1'b0);
        check_flag("busy", busy, 1'b0);
        if (sweeps_checked != sweeps_run) begin
            report_failure("the done pulse was not seen by the compare process");
        end
    endtask

    // compare process, a1 must match the expected vector whenever done is high
    always @(negedge clk) begin
        if (rst_n) begin
            if (done_q) begin
                check_flag("done", done, 1'b0);  // done lasts a single cycle
            end
            if (done) begin
                check_activation("a1", a1, exp_a1);
                sweeps_checked = sweeps_checked + 1;
            end
            done_q = done;
        end else begin
            done_q = 1'b0;
        end
    end

    initial begin
        neuron_idx_t     row_addr;
        activation_vec_t prev_a1;
        activation_vec_t onehot;

        void'($urandom(32'h559ad689));
        rst_n          = 1'b0;
        start          = 1'b0;
        x              = '0;
        wload          = '0;
        exp_a1         = '0;
        sweeps_run     = 0;
        sweeps_checked = 0;
        done_q         = 1'b0;

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        check_activation("a1", a1, '0);
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);

        load_all(1);  // every on pixel agrees
        x      = random_vec();
        exp_a1 = '1;
        run_sweep(-1);

        load_all(0);
        x      = random_vec();
        x[0]   = 1'b1;  // at least one pixel on, so every sum is negative
        exp_a1 = '0;
        run_sweep(-1);

        x      = '0;  // all sums are zero
        exp_a1 = '1;
        run_sweep(-1);

        load_all(2);
        for (int s = 0; s < 5; s++) begin
            x      = random_vec();
            exp_a1 = expected_activation(x);
            run_sweep((s == 2) ? 200 : -1);  // the third sweep sees a stray start
        end

        // a replacement row chosen so that its neuron must flip
        prev_a1  = a1;
        row_addr = neuron_idx_t'($urandom_range(N_NEURONS - 1, 0));
        write_row(row_addr, prev_a1[N_NEURONS-1-row_addr] ? '0 : '1);
        end_writes();
        onehot = '0;
        onehot[N_NEURONS-1-row_addr] = 1'b1;
        exp_a1 = expected_activation(x);
        run_sweep(-1);
        check_activation("a1 change after reload", a1 ^ prev_a1, onehot);

        if (sweeps_checked == sweeps_run) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            report_failure("fewer results were compared than sweeps were run");
        end
    end

endmodule

/* weight_store.sv */
`timescale 1ns/1ps

module weight_store (
    input  logic                        clk,
    input  logic                        rst_n,
    input  bnn_layer_pkg::weight_write_t wload,
    input  bnn_layer_pkg::neuron_idx_t  rd_addr,
    input  logic                        issue,
    output bnn_layer_pkg::row_read_t    rd
);
    import bnn_layer_pkg::*;

    weight_row_t mem [N_NEURONS];

    neuron_idx_t addr_q;
    logic        addr_vld;
    weight_row_t row_q;
    logic        row_vld;

    always_ff @(posedge clk) begin
        if (wload.en) begin
            mem[wload.addr] <= wload.row;
        end
    end

    // first read stage holds the address
    always_ff @(posedge clk) begin
        addr_q <= rd_addr;
    end

    // second read stage holds the row, which gives the two cycle latency
    always_ff @(posedge clk) begin
        row_q <= mem[addr_q];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_vld <= 1'b0;
            row_vld  <= 1'b0;
        end else begin
            addr_vld <= issue;
            row_vld  <= addr_vld;  // valid travels with the data
        end
    end

    assign rd = '{valid: row_vld, row: row_q};

    // loading a row in the middle of a sweep would mix two weight sets in one result
    no_write_in_sweep: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(wload.en && issue)
    );

endmodule
